// File: verilog/prefetch_pkg.sv
// Prefetch engine shared definitions
// Widths, word and address types, and the buffer sizing derived
// from the depth of the fetch pipeline
package prefetch_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------

    // Word address on the memory port
    localparam int ADDR_W = 16;
    // Memory word
    localparam int DATA_W = 32;
    // Request length in words
    localparam int LEN_W  = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;
    // Valid lengths are 1 to 255, zero requests are dropped
    typedef logic [LEN_W-1:0]  len_t;

    // ----------------------------------------
    // Buffer sizing
    // ----------------------------------------

    // Words that can still land after wr_rdy falls
    // One Wishbone cycle on the bus plus the capture register
    localparam int PIPELINE_DEPTH = 2;

    // Write to head register, through the memory and the FWFT stage
    localparam int WR_TO_EMPTY_LATENCY = 2;
    // Read to updated write count
    localparam int RD_TO_FULL_LATENCY  = 1;

    // Headroom for in-flight words on both sides of the ready decision
    localparam int FIFO_DEPTH = PIPELINE_DEPTH * 2 + 1 +
                                WR_TO_EMPTY_LATENCY + RD_TO_FULL_LATENCY;

endpackage : prefetch_pkg

// File: verilog/wb_rd_if.sv
// Fetch channel between prefetch controller and Wishbone read master
// Carries one-word read requests out and the captured words back
`timescale 1ns/1ps

interface wb_rd_if
    import prefetch_pkg::*;
();

    // One-cycle request pulse, only while busy is low
    logic  req;
    // Word address of the request
    addr_t addr;
    // Master has a read in progress
    logic  busy;
    // Captured word valid for one cycle
    logic  wvld;
    word_t wdata;

    // Request side
    modport ctrl (output req, output addr, input busy, input wvld);

    // Bus side
    modport master (input req, input addr, output busy, output wvld, output wdata);

    // Buffer side, write without handshake
    modport sink (input wvld, input wdata);

endinterface : wb_rd_if

// File: verilog/fifo_core.sv
// Single-clock first-word-fall-through FIFO
// Power-of-two memory plus a head register, registered write count,
// writes into a full FIFO are dropped and flagged, empty reads ignored
`timescale 1ns/1ps

module fifo_core #(
    parameter type DATA_T = logic [15:0],
    parameter int  DEPTH  = 8
) (
    input  logic                       clk,
    input  logic                       srst,

    input  logic                       wr,
    input  DATA_T                      wr_data,
    output logic [$clog2(DEPTH+1)-1:0] wr_count,
    output logic                       wr_oflow,

    input  logic                       rd,
    output logic                       rd_vld,
    output DATA_T                      rd_data
);

    // ----------------------------------------
    // Sizing
    // ----------------------------------------
    localparam int PTR_W     = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int MEM_DEPTH = 2 ** PTR_W;
    localparam int CNT_W     = $clog2(DEPTH + 1);

    // ----------------------------------------
    // Signals
    // ----------------------------------------
    DATA_T mem [MEM_DEPTH];

    // Extra top bit tells full memory from empty memory
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;

    logic           full;
    logic           wr_ok;
    logic           mem_empty;
    logic           head_load;
    logic           rd_ok;

    // Occupancy counts the head register too
    assign full      = (wr_count == CNT_W'(DEPTH));
    assign wr_ok     = wr && !full;
    assign mem_empty = (wr_ptr == rd_ptr);
    assign rd_ok     = rd && rd_vld;
    // Refill the head when it is empty or being taken
    assign head_load = !mem_empty && (!rd_vld || rd);

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr[PTR_W-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (head_load) begin
            rd_data <= mem[rd_ptr[PTR_W-1:0]];
        end
    end

    // ----------------------------------------
    // Pointers, head valid and count
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            rd_vld   <= 1'b0;
            wr_count <= '0;
            wr_oflow <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (head_load) begin
                rd_ptr <= rd_ptr + 1'b1;
                rd_vld <= 1'b1;
            end else if (rd_ok) begin
                rd_vld <= 1'b0;
            end
            // Net change of entries this cycle
            case ({wr_ok, rd_ok})
                2'b10:   wr_count <= wr_count + 1'b1;
                2'b01:   wr_count <= wr_count - 1'b1;
                default: wr_count <= wr_count;
            endcase
            // One-cycle flag per dropped word
            wr_oflow <= wr && full;
        end
    end

endmodule : fifo_core

// File: verilog/fifo_prefetch.sv
// Prefetch buffer
// FWFT FIFO whose write ready keeps room for every word still in the
// fetch pipeline, so writes issued while ready was high always fit
`timescale 1ns/1ps

module fifo_prefetch
    import prefetch_pkg::*;
#(
    parameter type DATA_T         = logic [15:0],
    // Writes that can still arrive after wr_rdy falls
    parameter int  PIPELINE_DEPTH = 2
) (
    input  logic  clk,
    input  logic  srst,

    input  logic  wr,
    output logic  wr_rdy,
    input  DATA_T wr_data,

    input  logic  rd,
    output logic  rd_vld,
    output DATA_T rd_data,

    // Set only when a word could not be stored
    output logic  oflow
);

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int RSV_W = $clog2(PIPELINE_DEPTH + 1);
    localparam int SUM_W = $clog2(FIFO_DEPTH + PIPELINE_DEPTH + 1);

    logic [CNT_W-1:0]          count;
    logic [PIPELINE_DEPTH-1:0] not_rdy_hist;
    logic [RSV_W-1:0]          not_rdy_ones;
    logic [RSV_W-1:0]          reserved;

    fifo_core #(
        .DATA_T ( DATA_T ),
        .DEPTH  ( FIFO_DEPTH )
    ) u_fifo_core (
        .clk      ( clk ),
        .srst     ( srst ),
        .wr       ( wr ),
        .wr_data  ( wr_data ),
        .wr_count ( count ),
        .wr_oflow ( oflow ),
        .rd       ( rd ),
        .rd_vld   ( rd_vld ),
        .rd_data  ( rd_data )
    );

    // ----------------------------------------
    // In-flight reservation
    // ----------------------------------------

    // Cycles in the window where no new fetch could have started
    always_ff @(posedge clk) begin
        if (srst) begin
            not_rdy_hist <= '0;
        end else begin
            not_rdy_hist <= (not_rdy_hist << 1) | PIPELINE_DEPTH'(!wr_rdy);
        end
    end

    always_comb begin
        not_rdy_ones = '0;
        for (int i = 0; i < PIPELINE_DEPTH; i++) begin
            not_rdy_ones = not_rdy_ones + RSV_W'(not_rdy_hist[i]);
        end
    end

    // Each ready cycle in the window may still deliver a word
    assign reserved = RSV_W'(PIPELINE_DEPTH) - not_rdy_ones;

    // Registered ready with the reserved slots counted as used
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_rdy <= 1'b0;
        end else begin
            wr_rdy <= (SUM_W'(count) + SUM_W'(reserved)) < SUM_W'(FIFO_DEPTH - 1);
        end
    end

endmodule : fifo_prefetch

// File: verilog/prefetch_ctrl.sv
// Prefetch request controller
// Latches a base and length, issues one fetch per word while the
// buffer has room, and stays busy until every word has returned
`timescale 1ns/1ps

module prefetch_ctrl
    import prefetch_pkg::*;
(
    input  logic       clk,
    input  logic       srst,

    // Consumer request
    input  logic       start,
    input  addr_t      base,
    input  len_t       len,

    // Buffer headroom
    input  logic       wr_rdy,

    output logic       busy,

    wb_rd_if.ctrl      fetch
);

    // ----------------------------------------
    // Request state
    // ----------------------------------------

    // Next word address to fetch
    addr_t issue_addr;
    // Words not yet requested
    len_t  issue_left;
    // Words not yet returned
    len_t  done_left;

    logic  accept;
    logic  issue;
    logic  last_done;

    // New request only when idle and non-empty
    assign accept = start && !busy && (len != '0);

    // One fetch at a time, only with buffer room
    assign issue = busy && (issue_left != '0) && wr_rdy && !fetch.busy;

    assign last_done = fetch.wvld && (done_left == len_t'(1));

    // Request goes straight out from the registered state
    assign fetch.req  = issue;
    assign fetch.addr = issue_addr;

    always_ff @(posedge clk) begin
        if (srst) begin
            busy       <= 1'b0;
            issue_left <= '0;
            done_left  <= '0;
        end else begin
            if (accept) begin
                busy       <= 1'b1;
                issue_left <= len;
                done_left  <= len;
            end else if (busy) begin
                if (issue) begin
                    issue_left <= issue_left - 1'b1;
                end
                if (fetch.wvld) begin
                    done_left <= done_left - 1'b1;
                end
                // Drop busy once the final word is in the buffer
                if (last_done) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Address wraps at the top of the word space
    always_ff @(posedge clk) begin
        if (accept) begin
            issue_addr <= base;
        end else if (issue) begin
            issue_addr <= issue_addr + 1'b1;
        end
    end

endmodule : prefetch_ctrl

// File: verilog/wb_read_master.sv
// Wishbone classic read master
// One single-word read per fetch request, address held until ack,
// returned word registered into a one-cycle capture stage
`timescale 1ns/1ps

module wb_read_master
    import prefetch_pkg::*;
(
    input  logic     clk,
    input  logic     srst,

    wb_rd_if.master  fetch,

    // Wishbone port
    output logic     wb_cyc,
    output logic     wb_stb,
    output logic     wb_we,
    output addr_t    wb_adr,
    input  word_t    wb_dat_i,
    input  logic     wb_ack
);

    typedef enum logic {
        S_IDLE,
        S_BUS
    } state_t;

    state_t state;

    // ----------------------------------------
    // Bus cycle
    // ----------------------------------------

    // Strobe and cycle follow the state register
    assign wb_cyc = (state == S_BUS);
    assign wb_stb = (state == S_BUS);
    // Read only
    assign wb_we  = 1'b0;

    assign fetch.busy = (state == S_BUS);

    always_ff @(posedge clk) begin
        if (srst) begin
            state      <= S_IDLE;
            fetch.wvld <= 1'b0;
        end else begin
            fetch.wvld <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (fetch.req) begin
                        state <= S_BUS;
                    end
                end
                S_BUS: begin
                    // Cycle ends on the edge that sees ack
                    if (wb_ack) begin
                        state      <= S_IDLE;
                        fetch.wvld <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Address held for the whole cycle
    always_ff @(posedge clk) begin
        if (state == S_IDLE && fetch.req) begin
            wb_adr <= fetch.addr;
        end
    end

    // Capture stage
    always_ff @(posedge clk) begin
        if (state == S_BUS && wb_ack) begin
            fetch.wdata <= wb_dat_i;
        end
    end

endmodule : wb_read_master

// File: verilog/prefetch_top.sv
// Memory read prefetch engine
// Controller issues Wishbone classic reads, returned words land in
// a prefetch buffer drained by the consumer through an FWFT port
`timescale 1ns/1ps

module prefetch_top
    import prefetch_pkg::*;
(
    input  logic  clk,
    input  logic  srst,

    // ----------------------------------------
    // Consumer port
    // ----------------------------------------
    input  logic  start,
    input  addr_t base,
    input  len_t  len,
    output logic  busy,
    input  logic  rd,
    output logic  rd_vld,
    output word_t rd_data,
    output logic  oflow,

    // ----------------------------------------
    // Wishbone memory port
    // ----------------------------------------
    output logic  wb_cyc,
    output logic  wb_stb,
    output logic  wb_we,
    output addr_t wb_adr,
    input  word_t wb_dat_i,
    input  logic  wb_ack
);

    logic wr_rdy;

    // Fetch channel between controller, master and buffer
    wb_rd_if fetch_if ();

    prefetch_ctrl u_ctrl (
        .clk    ( clk ),
        .srst   ( srst ),
        .start  ( start ),
        .base   ( base ),
        .len    ( len ),
        .wr_rdy ( wr_rdy ),
        .busy   ( busy ),
        .fetch  ( fetch_if.ctrl )
    );

    wb_read_master u_master (
        .clk      ( clk ),
        .srst     ( srst ),
        .fetch    ( fetch_if.master ),
        .wb_cyc   ( wb_cyc ),
        .wb_stb   ( wb_stb ),
        .wb_we    ( wb_we ),
        .wb_adr   ( wb_adr ),
        .wb_dat_i ( wb_dat_i ),
        .wb_ack   ( wb_ack )
    );

    // Captured words written without handshake
    fifo_prefetch #(
        .DATA_T         ( word_t ),
        .PIPELINE_DEPTH ( PIPELINE_DEPTH )
    ) u_buf (
        .clk     ( clk ),
        .srst    ( srst ),
        .wr      ( fetch_if.wvld ),
        .wr_rdy  ( wr_rdy ),
        .wr_data ( fetch_if.wdata ),
        .rd      ( rd ),
        .rd_vld  ( rd_vld ),
        .rd_data ( rd_data ),
        .oflow   ( oflow )
    );

endmodule : prefetch_top

// File: verif/wb_mem_model.sv
// Wishbone classic slave memory for the prefetch testbench
// 64K words of seeded random data, random wait cycles before each ack
`timescale 1ns/1ps

module wb_mem_model
    import prefetch_pkg::*;
(
    input  logic  clk,
    input  logic  srst,
    input  logic  wb_cyc,
    input  logic  wb_stb,
    input  logic  wb_we,
    input  addr_t wb_adr,
    output word_t wb_dat_o,
    output logic  wb_ack
);

    int    seed = 18;
    word_t mem [2**ADDR_W];
    // Strobe seen and wait count drawn
    logic  armed;
    int    wait_left;

    // Random contents, fixed seed
    initial begin
        for (int i = 0; i < 2**ADDR_W; i++) begin
            mem[i] = $random(seed);
        end
    end

    // Reads only, a write cycle never gets an ack
    always @(posedge clk) begin
        if (srst) begin
            wb_ack <= 1'b0;
            armed  <= 1'b0;
        end else begin
            // Ack is a single-cycle pulse
            wb_ack <= 1'b0;
            if (wb_cyc && wb_stb && !wb_we && !wb_ack) begin
                if (!armed) begin
                    armed     <= 1'b1;
                    wait_left <= {$random(seed)} % 4;
                end else if (wait_left == 0) begin
                    armed    <= 1'b0;
                    wb_ack   <= 1'b1;
                    wb_dat_o <= mem[wb_adr];
                end else begin
                    wait_left <= wait_left - 1;
                end
            end
        end
    end

endmodule : wb_mem_model

// File: verif/tb_prefetch.sv
// Testbench for the memory read prefetch engine
// Random requests and consumer stalls against a queue model of the
// expected words, plus Wishbone protocol and buffer checks
`timescale 1ns/1ps

module tb_prefetch
    import prefetch_pkg::*;
();

    // ----------------------------------------
    // Constants and signals
    // ----------------------------------------
    localparam int WAIT_LIMIT   = 20000;
    localparam int NUM_REQUESTS = 20;
    localparam int STALL_CYCLES = 200;

    logic  clk;
    logic  srst;
    logic  start;
    addr_t base;
    len_t  len;
    logic  busy;
    logic  rd;
    logic  rd_vld;
    word_t rd_data;
    logic  oflow;
    logic  wb_cyc;
    logic  wb_stb;
    logic  wb_we;
    addr_t wb_adr;
    word_t wb_dat_i;
    logic  wb_ack;

    int    seed = 18;
    // Expected words in delivery order
    word_t exp_q [$];
    // Address of the next acked bus cycle
    addr_t exp_adr;
    bit    hold_rd;
    int    acks;
    int    got_count;
    int    errors;
    int    test_num;
    int    tests_failed;
    int    err_start;
    string test_name;

    prefetch_top DUT (
        .clk      ( clk ),
        .srst     ( srst ),
        .start    ( start ),
        .base     ( base ),
        .len      ( len ),
        .busy     ( busy ),
        .rd       ( rd ),
        .rd_vld   ( rd_vld ),
        .rd_data  ( rd_data ),
        .oflow    ( oflow ),
        .wb_cyc   ( wb_cyc ),
        .wb_stb   ( wb_stb ),
        .wb_we    ( wb_we ),
        .wb_adr   ( wb_adr ),
        .wb_dat_i ( wb_dat_i ),
        .wb_ack   ( wb_ack )
    );

    wb_mem_model u_mem (
        .clk      ( clk ),
        .srst     ( srst ),
        .wb_cyc   ( wb_cyc ),
        .wb_stb   ( wb_stb ),
        .wb_we    ( wb_we ),
        .wb_adr   ( wb_adr ),
        .wb_dat_o ( wb_dat_i ),
        .wb_ack   ( wb_ack )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // Reporting
    // ----------------------------------------
    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    task automatic start_test(string name);
        test_num++;
        test_name = name;
        err_start = errors;
    endtask

    task automatic end_test();
        if (errors == err_start) begin
            $display("Test %0d %s: pass", test_num, test_name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: fail, %0d errors", test_num, test_name, errors - err_start);
        end
    endtask

    task automatic finish_run();
        $display("Tests run %0d, failed %0d, errors %0d", test_num, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(string what);
        errors++;
        tests_failed++;
        $display("ERROR at %0t: timed out waiting for %s", $time, what);
        finish_run();
    endtask

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------

    // One start pulse
    // The model takes the words only when the engine is known to be idle
    task automatic run_request(addr_t b, len_t l, bit idle);
        start <= 1'b1;
        base  <= b;
        len   <= l;
        if (idle && l != '0) begin
            for (int i = 0; i < int'(l); i++) begin
                exp_q.push_back(u_mem.mem[addr_t'(b + addr_t'(i))]);
            end
            exp_adr <= b;
        end
        @(negedge clk);
        start <= 1'b0;
    endtask

    // Idle and drained for a few cycles in a row
    // The last word can still be in the FWFT path when busy falls
    task automatic wait_done(string what);
        int cycles;
        int quiet;
        cycles = 0;
        quiet  = 0;
        while (quiet < 3) begin
            if (cycles >= WAIT_LIMIT) report_timeout(what);
            @(negedge clk);
            cycles++;
            if (!busy && !rd_vld) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
        check_value("words left in model", exp_q.size(), 0);
    endtask

    // ----------------------------------------
    // Consumer with random stalls
    // ----------------------------------------
    initial begin
        rd <= 1'b0;
        forever begin
            @(negedge clk);
            if (srst) begin
                rd <= 1'b0;
            end else begin
                rd <= 1'b0;
                if (!hold_rd && ({$random(seed)} % 4) != 0) begin
                    rd <= 1'b1;
                    // Head taken on the next rising edge
                    if (rd_vld) begin
                        if (exp_q.size() == 0) begin
                            errors++;
                            $display("ERROR at %0t: word %0h delivered with none expected",
                                     $time, rd_data);
                        end else begin
                            check_value("rd_data", rd_data, exp_q.pop_front());
                        end
                        got_count <= got_count + 1;
                    end
                end
            end
        end
    end

    // ----------------------------------------
    // Bus and buffer monitor
    // ----------------------------------------
    always @(negedge clk) begin
        if (!srst) begin
            assert (wb_cyc || !wb_stb) else begin
                errors++;
                $display("ERROR at %0t: wb_stb high without wb_cyc", $time);
            end
            check_value("wb_we", wb_we, 0);
            check_value("oflow", oflow, 0);
            // Addresses run up by one per acked cycle
            if (wb_cyc && wb_ack) begin
                check_value("wb_adr", 32'(wb_adr), 32'(exp_adr));
                exp_adr <= exp_adr + 1'b1;
                acks    <= acks + 1;
            end
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        addr_t b;
        len_t  l;
        int    total;
        int    mark;
        int    cycles;

        srst  <= 1'b1;
        start <= 1'b0;
        base  <= '0;
        len   <= '0;
        repeat (2) @(negedge clk);
        srst <= 1'b0;
        @(negedge clk);

        start_test("data order");
        for (int n = 0; n < NUM_REQUESTS; n++) begin
            // Last one crosses the top of the address space
            b = (n == NUM_REQUESTS - 1) ? 16'hfffa : addr_t'($random(seed));
            l = (n == NUM_REQUESTS - 1) ? 8'd16 : len_t'({$random(seed)} % 48 + 1);
            run_request(b, l, 1'b1);
            wait_done("data order request");
        end
        end_test();

        start_test("bus protocol");
        mark  = acks;
        total = 0;
        for (int n = 0; n < 5; n++) begin
            l = len_t'({$random(seed)} % 16 + 1);
            total += int'(l);
            run_request(addr_t'($random(seed)), l, 1'b1);
            wait_done("bus protocol request");
        end
        check_value("acked cycles", acks - mark, total);
        end_test();

        start_test("back-pressure");
        mark = got_count;
        hold_rd <= 1'b1;
        run_request(addr_t'($random(seed)), 8'd60, 1'b1);
        repeat (STALL_CYCLES / 2) @(negedge clk);
        total = acks;
        repeat (STALL_CYCLES / 2) @(negedge clk);
        // Fetching has stopped with the buffer full
        check_value("acks during stall", acks, total);
        check_value("wb_cyc during stall", wb_cyc, 0);
        check_value("busy during stall", busy, 1);
        hold_rd <= 1'b0;
        wait_done("back-pressure drain");
        check_value("words after stall", got_count - mark, 60);
        end_test();

        start_test("length edges");
        mark = got_count;
        run_request(addr_t'($random(seed)), 8'd1, 1'b1);
        wait_done("length 1");
        check_value("words for length 1", got_count - mark, 1);
        mark = got_count;
        run_request(addr_t'($random(seed)), 8'd255, 1'b1);
        wait_done("length 255");
        check_value("words for length 255", got_count - mark, 255);
        mark = got_count;
        run_request(addr_t'($random(seed)), 8'd0, 1'b1);
        repeat (8) begin
            @(negedge clk);
            check_value("busy for length 0", busy, 0);
        end
        check_value("words for length 0", got_count - mark, 0);
        end_test();

        start_test("start while busy");
        mark = got_count;
        run_request(addr_t'($random(seed)), 8'd12, 1'b1);
        repeat (3) @(negedge clk);
        check_value("busy before second start", busy, 1);
        // The DUT ignores this start and the model adds nothing
        run_request(addr_t'($random(seed)), 8'd12, 1'b0);
        wait_done("start while busy");
        check_value("words delivered", got_count - mark, 12);
        end_test();

        start_test("reset mid-transfer");
        run_request(addr_t'($random(seed)), 8'd50, 1'b1);
        mark   = acks;
        cycles = 0;
        while (acks < mark + 5) begin
            if (cycles >= WAIT_LIMIT) report_timeout("words before reset");
            @(negedge clk);
            cycles++;
        end
        hold_rd <= 1'b1;
        @(negedge clk);
        // Reset drops every buffered and in-flight word
        exp_q.delete();
        srst <= 1'b1;
        repeat (2) @(negedge clk);
        srst    <= 1'b0;
        hold_rd <= 1'b0;
        check_value("busy after reset", busy, 0);
        check_value("wb_cyc after reset", wb_cyc, 0);
        check_value("rd_vld after reset", rd_vld, 0);
        @(negedge clk);
        mark = got_count;
        run_request(addr_t'($random(seed)), 8'd9, 1'b1);
        wait_done("request after reset");
        check_value("words after reset", got_count - mark, 9);
        end_test();

        finish_run();
    end

endmodule : tb_prefetch

// File: flist.f
verilog/prefetch_pkg.sv
verilog/wb_rd_if.sv
verilog/fifo_core.sv
verilog/fifo_prefetch.sv
verilog/prefetch_ctrl.sv
verilog/wb_read_master.sv
verilog/prefetch_top.sv
verif/wb_mem_model.sv
verif/tb_prefetch.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the prefetch testbench with Verilator, result taken from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_prefetch -f flist.f \
    && ./obj_dir/Vtb_prefetch | tee sim.log
grep -q "Result: PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
